// ==== rtl/filter_pkg.sv ====
package filter_pkg;

    // widths of the event record
    localparam int TS_W   = 16;
    localparam int EVT_W  = TS_W + 1;
    localparam int DROP_W = 8;

    // free-running cycle stamp, wraps around
    typedef logic [TS_W-1:0] ts_t;

    // {polarity, timestamp}, polarity 1 means rising
    typedef logic [EVT_W-1:0] event_t;

    // saturating overflow count
    typedef logic [DROP_W-1:0] drop_cnt_t;

    // host port sequencing
    typedef enum logic [1:0] {
        idle,
        load,
        req_high,
        wait_ack_low
    } port_state_t;

    // pack one edge into an event record
    function automatic event_t make_event(
        input logic rising,
        input ts_t  stamp
    );
        event_t ev;
        ev = {rising, stamp};
        return ev;
    endfunction

endpackage

// ==== rtl/input_filter.sv ====
module input_filter #(
    parameter int STABLE_CYCLES = 8
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sig_in,
    output logic pos_flag,
    output logic neg_flag
);

    // counter only has to hold 0 .. STABLE_CYCLES-1
    localparam int CNT_W = $clog2(STABLE_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STABLE_CYCLES - 1);

    logic             sync_q1;
    logic             sync_q2;
    logic             stable_lvl;
    logic [CNT_W-1:0] settle_cnt;
    logic             differ;
    logic             settle_done;

    // two-flop synchronizer, starts at the idle level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
        end else begin
            sync_q1 <= sig_in;
            sync_q2 <= sync_q1;
        end
    end

    assign differ = sync_q2 != stable_lvl;

    // last disagreeing sample before the level may flip
    assign settle_done = differ && (settle_cnt == CNT_LAST);

    // consecutive disagreeing samples
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            settle_cnt <= '0;
        end else if (!differ || settle_done) begin
            settle_cnt <= '0;
        end else begin
            settle_cnt <= settle_cnt + 1'b1;
        end
    end

    // filtered level, only follows the input once it has settled
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stable_lvl <= 1'b1;
        end else if (settle_done) begin
            stable_lvl <= sync_q2;
        end
    end

    // one-cycle direction flags, high in the cycle after the flip
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_flag <= 1'b0;
            neg_flag <= 1'b0;
        end else begin
            pos_flag <= settle_done && sync_q2;
            neg_flag <= settle_done && !sync_q2;
        end
    end

endmodule

// ==== rtl/edge_event_queue.sv ====
module edge_event_queue
    import filter_pkg::*;
#(
    parameter int DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pos_flag,
    input  logic      neg_flag,
    input  logic      q_pop,
    output event_t    q_data,
    output logic      q_empty,
    output drop_cnt_t drop_count
);

    localparam int AW = $clog2(DEPTH);

    event_t      mem [DEPTH];
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    ts_t         ts_cnt;
    logic        flag_in;
    logic        q_full;
    logic        do_write;
    logic        do_read;

    assign flag_in = pos_flag | neg_flag;

    // extra pointer bit tells full from empty
    assign q_empty = wr_ptr == rd_ptr;
    assign q_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    assign do_write = flag_in && !q_full;
    assign do_read  = q_pop && !q_empty;

    assign q_data = mem[rd_ptr[AW-1:0]];

    // cycle stamp, runs from reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ts_cnt <= '0;
        end else begin
            ts_cnt <= ts_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[AW-1:0]] <= make_event(pos_flag, ts_cnt);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // flags arriving on a full queue are lost, count them
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (flag_in && q_full && (drop_count != '1)) begin
            drop_count <= drop_count + 1'b1;
        end
    end

endmodule

// ==== rtl/host_event_port.sv ====
module host_event_port
    import filter_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  event_t q_data,
    input  logic   q_empty,
    output logic   q_pop,
    output event_t ev_data,
    output logic   ev_req,
    input  logic   ev_ack
);

    port_state_t state;

    // head entry leaves the queue at the end of load
    assign q_pop = state == load;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= idle;
            ev_req <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (!q_empty) begin
                        state <= load;
                    end
                end
                load: begin
                    state <= req_high;
                end
                req_high: begin
                    // data was set a cycle earlier, now raise the request
                    if (!ev_req) begin
                        ev_req <= 1'b1;
                    end else if (ev_ack) begin
                        ev_req <= 1'b0;
                        state  <= wait_ack_low;
                    end
                end
                wait_ack_low: begin
                    // transfer ends when the host drops ack
                    if (!ev_ack) begin
                        state <= idle;
                    end
                end
                default: begin
                    state  <= idle;
                    ev_req <= 1'b0;
                end
            endcase
        end
    end

    // held until the next load, so stable during the request
    always_ff @(posedge clk) begin
        if (state == load) begin
            ev_data <= q_data;
        end
    end

endmodule

// ==== rtl/filter_top.sv ====
module filter_top
    import filter_pkg::*;
#(
    parameter int STABLE_CYCLES = 8,
    parameter int DEPTH         = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sig_in,
    output event_t    ev_data,
    output logic      ev_req,
    input  logic      ev_ack,
    output drop_cnt_t drop_count
);

    logic   pos_flag;
    logic   neg_flag;
    event_t q_data;
    logic   q_empty;
    logic   q_pop;

    input_filter #(
        .STABLE_CYCLES (STABLE_CYCLES)
    ) u_filter (
        .clk      (clk),
        .rst_n    (rst_n),
        .sig_in   (sig_in),
        .pos_flag (pos_flag),
        .neg_flag (neg_flag)
    );

    edge_event_queue #(
        .DEPTH (DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .pos_flag   (pos_flag),
        .neg_flag   (neg_flag),
        .q_pop      (q_pop),
        .q_data     (q_data),
        .q_empty    (q_empty),
        .drop_count (drop_count)
    );

    host_event_port u_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .q_data  (q_data),
        .q_empty (q_empty),
        .q_pop   (q_pop),
        .ev_data (ev_data),
        .ev_req  (ev_req),
        .ev_ack  (ev_ack)
    );

endmodule

// ==== tests/filter_chk.sv ====
module filter_chk
    import filter_pkg::*;
(
    input logic   clk,
    input logic   rst_n,
    input logic   ev_req,
    input logic   ev_ack,
    input event_t ev_data,
    input logic   pos_flag,
    input logic   neg_flag
);

    int fail_count = 0;

    // host samples ev_data any time while the request is up
    data_held: assert property (@(posedge clk) disable iff (!rst_n)
        ev_req && $past(ev_req) |-> ev_data == $past(ev_data))
        else begin
            $error("ev_data changed while ev_req was high");
            fail_count++;
        end

    // a new transfer only starts once ack is back low
    req_after_ack_low: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ev_req) |-> !$past(ev_ack))
        else begin
            $error("ev_req rose while ev_ack was still high");
            fail_count++;
        end

    req_drop_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ev_req) |-> $past(ev_ack))
        else begin
            $error("ev_req dropped without ev_ack");
            fail_count++;
        end

    flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(pos_flag && neg_flag))
        else begin
            $error("pos_flag and neg_flag high together");
            fail_count++;
        end

    pos_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        pos_flag |=> !pos_flag)
        else begin
            $error("pos_flag longer than one cycle");
            fail_count++;
        end

    neg_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        neg_flag |=> !neg_flag)
        else begin
            $error("neg_flag longer than one cycle");
            fail_count++;
        end

endmodule

bind host_event_port filter_chk chk_port (
    .clk      (clk),
    .rst_n    (rst_n),
    .ev_req   (ev_req),
    .ev_ack   (ev_ack),
    .ev_data  (ev_data),
    .pos_flag (1'b0),
    .neg_flag (1'b0)
);

bind input_filter filter_chk chk_flags (
    .clk      (clk),
    .rst_n    (rst_n),
    .ev_req   (1'b0),
    .ev_ack   (1'b0),
    .ev_data  ('0),
    .pos_flag (pos_flag),
    .neg_flag (neg_flag)
);

// ==== tests/event_monitor.sv ====
module event_monitor
    import filter_pkg::*;
#(
    parameter int STABLE_CYCLES = 8,
    parameter int DEPTH         = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      sig_in,
    input  logic      ev_ack,
    input  event_t    ev_data,
    input  logic      ev_req,
    input  drop_cnt_t drop_count,
    output int        err_count,
    output int        pending,
    output int        delivered
);

    // model state
    logic        m_s1;
    logic        m_s2;
    logic        m_lvl;
    int          m_run;
    logic        m_pos;
    logic        m_neg;
    ts_t         m_ts;
    drop_cnt_t   m_drop;
    port_state_t m_st;
    logic        m_req;
    logic        req_seen;
    event_t      m_q[$];
    event_t      exp_q[$];

    initial begin
        err_count = 0;
        pending   = 0;
        delivered = 0;
    end

    task automatic reset_model();
        m_s1     = 1'b1;
        m_s2     = 1'b1;
        m_lvl    = 1'b1;
        m_run    = 0;
        m_pos    = 1'b0;
        m_neg    = 1'b0;
        m_ts     = '0;
        m_drop   = '0;
        m_st     = idle;
        m_req    = 1'b0;
        req_seen = 1'b0;
        m_q.delete();
        exp_q.delete();
    endtask

    task automatic compare_outputs();
        event_t want;
        if (drop_count !== m_drop) begin
            $display("Error: time %0t drop_count expected %0d actual %0d",
                     $time, m_drop, drop_count);
            err_count++;
        end
        if (ev_req !== m_req) begin
            $display("Error: time %0t ev_req expected %b actual %b", $time, m_req, ev_req);
            err_count++;
        end
        // each new request carries the next expected event
        if (ev_req && !req_seen) begin
            if (exp_q.size() == 0) begin
                $display("time %0t: the host got event %h that the model never produced",
                         $time, ev_data);
                err_count++;
            end else begin
                want = exp_q.pop_front();
                if (ev_data !== want) begin
                    $display("Error: time %0t ev_data expected %h actual %h",
                             $time, want, ev_data);
                    err_count++;
                end
                delivered++;
            end
        end
        req_seen = ev_req;
    endtask

    task automatic step_model();
        logic pop_now;
        logic full;
        logic differ;
        logic flip;
        pop_now = 1'b0;
        // port sees the queue as it stood before this edge
        case (m_st)
            idle: begin
                if (m_q.size() != 0) begin
                    m_st = load;
                end
            end
            load: begin
                exp_q.push_back(m_q[0]);
                pop_now = 1'b1;
                m_st    = req_high;
            end
            req_high: begin
                if (!m_req) begin
                    m_req = 1'b1;
                end else if (ev_ack) begin
                    m_req = 1'b0;
                    m_st  = wait_ack_low;
                end
            end
            default: begin
                if (!ev_ack) begin
                    m_st = idle;
                end
            end
        endcase
        full = m_q.size() == DEPTH;
        if (pop_now) begin
            void'(m_q.pop_front());
        end
        if (m_pos || m_neg) begin
            if (full) begin
                if (m_drop != '1) begin
                    m_drop = m_drop + 1'b1;
                end
            end else begin
                m_q.push_back({m_pos, m_ts});
            end
        end
        // level flips on the STABLE_CYCLES-th disagreeing sample in a row
        differ = m_s2 != m_lvl;
        flip   = differ && (m_run + 1 == STABLE_CYCLES);
        m_pos  = flip && m_s2;
        m_neg  = flip && !m_s2;
        if (!differ || flip) begin
            m_run = 0;
        end else begin
            m_run++;
        end
        if (flip) begin
            m_lvl = m_s2;
        end
        m_s2 = m_s1;
        m_s1 = sig_in;
        m_ts = m_ts + 1'b1;
        pending = m_q.size() + exp_q.size();
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            compare_outputs();
            step_model();
        end
    end

    task automatic report_undelivered();
        foreach (exp_q[i]) begin
            $display("event %h was taken by the port but never reached the host", exp_q[i]);
        end
        foreach (m_q[i]) begin
            $display("event %h is still waiting in the queue", m_q[i]);
        end
    endtask

endmodule

// ==== tests/tb_top.sv ====
module tb_top
    import filter_pkg::*;
();

    localparam int STABLE_CYCLES = 8;
    localparam int DEPTH         = 4;
    localparam int FIRST_SEGS    = 40;
    localparam int LAST_SEGS     = 20;
    localparam int NUM_SEG       = FIRST_SEGS + LAST_SEGS;
    localparam int MAX_SEG       = 3 * STABLE_CYCLES + 8;
    localparam int SLOW_DELAY    = 40;
    localparam int SLOW_EVENTS   = 10;
    localparam int SLOW_CYCLES   = SLOW_EVENTS * (STABLE_CYCLES + 2) +
                                   (DEPTH + 1) * (2 * SLOW_DELAY + 8);
    localparam int CYCLE_LIMIT   = (NUM_SEG * MAX_SEG + SLOW_CYCLES) * 2;

    logic        clk;
    logic        rst_n;
    logic        sig_in;
    logic        ev_ack;
    event_t      ev_data;
    logic        ev_req;
    drop_cnt_t   drop_count;
    int          mon_errors;
    int          pending;
    int          delivered;
    int          cycles = 0;
    logic        cur_lvl = 1'b1;
    logic        slow_host = 1'b0;
    logic [31:0] stim_state = 32'h4cc2;
    logic [31:0] ack_state = 32'h4cc2;

    filter_top #(
        .STABLE_CYCLES (STABLE_CYCLES),
        .DEPTH         (DEPTH)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .sig_in     (sig_in),
        .ev_data    (ev_data),
        .ev_req     (ev_req),
        .ev_ack     (ev_ack),
        .drop_count (drop_count)
    );

    event_monitor #(
        .STABLE_CYCLES (STABLE_CYCLES),
        .DEPTH         (DEPTH)
    ) mon (
        .clk        (clk),
        .rst_n      (rst_n),
        .sig_in     (sig_in),
        .ev_ack     (ev_ack),
        .ev_data    (ev_data),
        .ev_req     (ev_req),
        .drop_count (drop_count),
        .err_count  (mon_errors),
        .pending    (pending),
        .delivered  (delivered)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // separate streams so stimulus and host timing stay independent
    function int stim_rand(input int n);
        stim_state = lcg_step(stim_state);
        return int'(stim_state[23:16]) % n;
    endfunction

    function int ack_rand(input int n);
        ack_state = lcg_step(ack_state);
        return int'(ack_state[23:16]) % n;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic hold_level(input logic v, input int n);
        sig_in = v;
        repeat (n) next_cycle();
    endtask

    task automatic glitch_burst(input int pulses);
        repeat (pulses) begin
            hold_level(!cur_lvl, 1);
            hold_level(cur_lvl, 1);
        end
        hold_level(cur_lvl, STABLE_CYCLES + 2);
    endtask

    task automatic near_miss();
        hold_level(!cur_lvl, STABLE_CYCLES - 1);
        hold_level(cur_lvl, STABLE_CYCLES + 2);
    endtask

    task automatic settled_change(input int extra);
        hold_level(!cur_lvl, STABLE_CYCLES + extra);
        cur_lvl = !cur_lvl;
    endtask

    task automatic run_segments(input int count);
        int kind;
        for (int i = 0; i < count; i++) begin
            kind = stim_rand(3);
            if (kind == 0) begin
                glitch_burst(1 + stim_rand(STABLE_CYCLES - 1));
            end else if (kind == 1) begin
                settled_change(stim_rand(8));
            end else begin
                near_miss();
            end
        end
    endtask

    // let the last flag through, then wait for the host to take everything
    task automatic drain();
        hold_level(cur_lvl, 2 * STABLE_CYCLES);
        while (pending != 0 || ev_req || ev_ack) begin
            next_cycle();
        end
    endtask

    task automatic slow_phase();
        slow_host = 1'b1;
        repeat (SLOW_EVENTS) settled_change(2);
        slow_host = 1'b0;
        drain();
    endtask

    task automatic close_run(input logic timed_out);
        int chk_fails;
        int other;
        int total;
        mon.report_undelivered();
        chk_fails = uut.u_port.chk_port.fail_count + uut.u_filter.chk_flags.fail_count;
        other = timed_out ? 1 : 0;
        if (delivered == 0) begin
            $display("no event reached the host during the whole run");
            other++;
        end
        total = mon_errors + pending + chk_fails + other;
        $display("value errors %0d, undelivered events %0d, assertion failures %0d, other %0d",
                 mon_errors, pending, chk_fails, other);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    // host side, ack after a random number of cycles
    always begin
        int wait_n;
        next_cycle();
        if (rst_n && ev_req && !ev_ack) begin
            wait_n = slow_host ? SLOW_DELAY : ack_rand(7);
            repeat (wait_n) next_cycle();
            ev_ack = 1'b1;
            while (ev_req) begin
                next_cycle();
            end
            wait_n = slow_host ? SLOW_DELAY : ack_rand(7);
            repeat (wait_n) next_cycle();
            ev_ack = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycles);
            close_run(1'b1);
        end
    end

    initial begin
        clk    = 1'b0;
        rst_n  = 1'b0;
        sig_in = 1'b1;
        ev_ack = 1'b0;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        hold_level(1'b1, 2 * STABLE_CYCLES);
        run_segments(FIRST_SEGS);
        drain();
        slow_phase();
        run_segments(LAST_SEGS);
        drain();
        close_run(1'b0);
    end

endmodule

// ==== tb.f ====
rtl/filter_pkg.sv
rtl/input_filter.sv
rtl/edge_event_queue.sv
rtl/host_event_port.sv
rtl/filter_top.sv
tests/filter_chk.sv
tests/event_monitor.sv
tests/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := tb.f
VFLAGS    := --binary --timing --assert
OBJ_DIR   := obj_dir
RUN_ARGS  := +verilator+error+limit+1000
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
